//--- Bender.yml
package:
  name: apb_subsystem

sources:
  - verilog/apb_sub_pkg.sv
  - verilog/apb_if.sv
  - verilog/ahb_apb_fsm.sv
  - verilog/apb_wait_timer.sv
  - verilog/apb_slot_decode.sv
  - verilog/alut_regs.sv
  - verilog/apb_subsystem.sv
  - target: test
    files:
      - tests/apb_subsystem_checker.sv
      - tests/apb_subsystem_tb.sv

//--- compile.f
verilog/apb_sub_pkg.sv
verilog/apb_if.sv
verilog/ahb_apb_fsm.sv
verilog/apb_wait_timer.sv
verilog/apb_slot_decode.sv
verilog/alut_regs.sv
verilog/apb_subsystem.sv
tests/apb_subsystem_checker.sv
tests/apb_subsystem_tb.sv

//--- tests/apb_subsystem_checker.sv
//--------------------
// Protocol assertions bound into the APB subsystem top level
// Watches MAC selects, the APB access phase and the AHB error response
//--------------------
`timescale 1ns/1ps

module apb_subsystem_checker (
   input logic                hclk,
   input logic                rst_n,
   input logic [3:0]          psel_mac,
   input logic                psel,
   input logic                penable,
   input apb_sub_pkg::word_t  paddr,
   input logic                hready,
   input apb_sub_pkg::hresp_t hresp
);
   import apb_sub_pkg::*;

   // MAC selects placed in the slot map, ALUT bit left clear
   slot_mask_t mac_mask;

   assign mac_mask = {psel_mac, 1'b0};

   // At most one external port selected
   a_mac_onehot: assert property (@(posedge hclk) disable iff (!rst_n)
      $onehot0(mac_mask))
      else $error("More than one MAC port selected");

   // Access phase only straight after a setup cycle
   a_enable_after_setup: assert property (@(posedge hclk) disable iff (!rst_n)
      $rose(penable) |-> $past(psel && !penable))
      else $error("penable rose without a setup cycle before it");

   a_addr_stable: assert property (@(posedge hclk) disable iff (!rst_n)
      penable |-> $stable(paddr))
      else $error("paddr changed during the access phase");

   // Two-cycle ERROR response
   a_error_two_cycle: assert property (@(posedge hclk) disable iff (!rst_n)
      (hresp == HRESP_ERROR) && !hready |=> (hresp == HRESP_ERROR) && hready)
      else $error("First ERROR cycle not followed by ERROR with hready high");

endmodule

bind apb_subsystem apb_subsystem_checker u_checker (
   .hclk     (hclk),
   .rst_n    (rst_n),
   .psel_mac (psel_mac),
   .psel     (bus_if.psel),
   .penable  (penable),
   .paddr    (paddr),
   .hready   (hready),
   .hresp    (hresp)
);

//--- tests/apb_subsystem_tb.sv
//--------------------
// Testbench for the APB subsystem, AHB transfers applied from a table
// Four MAC models with random pready delay answer slots 1 to 4
// Prints one line per test and a summary line at the end
//--------------------
`timescale 1ns/1ps

module apb_subsystem_tb;
   import apb_sub_pkg::*;

   localparam int WAIT_LIMIT = 16;
   localparam int ALUT_DEPTH = 8;
   // Longest legal transfer is a timeout plus the error cycles
   localparam int MAX_WAIT   = WAIT_LIMIT + 8;

   // One AHB transfer with its expected outcome
   typedef struct {
      int          test;
      int          slot;
      logic [15:0] offset;
      logic        write;
      word_t       wdata;
      hresp_t      exp_resp;
      word_t       exp_rdata;
      logic        chk_rdata;
      logic [3:0]  stall;
   } xfer_t;

   logic       hclk;
   logic       rst_n;
   logic       hsel;
   word_t      haddr;
   htrans_t    htrans;
   logic       hwrite;
   word_t      hwdata;
   logic       hready_in;
   word_t      hrdata;
   logic       hready;
   hresp_t     hresp;
   word_t      paddr;
   logic       pwrite;
   logic       penable;
   word_t      pwdata;
   word_t      prdata_mac [4] = '{default: '0};
   logic [3:0] pready_mac = '0;
   logic [3:0] psel_mac;

   // MAC model state
   word_t       mac_mem [4][64];
   int          wait_cnt [4];
   logic [3:0]  stall = '0;
   logic [31:0] lcg_state;

   xfer_t table_q [$];
   int    errors;
   int    checks;
   int    tests_run;
   int    tests_failed;
   int    test_err_mark;

   apb_subsystem #(
      .WAIT_LIMIT (WAIT_LIMIT),
      .ALUT_DEPTH (ALUT_DEPTH)
   ) UUT (
      .hclk        (hclk),
      .rst_n       (rst_n),
      .hsel        (hsel),
      .haddr       (haddr),
      .htrans      (htrans),
      .hwrite      (hwrite),
      .hwdata      (hwdata),
      .hready_in   (hready_in),
      .hrdata      (hrdata),
      .hready      (hready),
      .hresp       (hresp),
      .paddr       (paddr),
      .pwrite      (pwrite),
      .penable     (penable),
      .pwdata      (pwdata),
      .prdata_mac0 (prdata_mac[0]),
      .prdata_mac1 (prdata_mac[1]),
      .prdata_mac2 (prdata_mac[2]),
      .prdata_mac3 (prdata_mac[3]),
      .pready_mac0 (pready_mac[0]),
      .pready_mac1 (pready_mac[1]),
      .pready_mac2 (pready_mac[2]),
      .pready_mac3 (pready_mac[3]),
      .psel_mac0   (psel_mac[0]),
      .psel_mac1   (psel_mac[1]),
      .psel_mac2   (psel_mac[2]),
      .psel_mac3   (psel_mac[3])
   );

   initial begin
      hclk = 1'b0;
      forever #50 hclk = ~hclk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   //--------------------
   // MAC slave models
   //--------------------
   always @(posedge hclk) begin
      if (!rst_n) begin
         pready_mac <= '0;
         lcg_state = 32'h74f3;
         // Fill pattern from port and word index
         for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 64; j++) begin
               mac_mem[i][j] <= 32'h5A00_0000 | word_t'(i << 8) | word_t'(j);
            end
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (psel_mac[i] && !penable) begin
               // Setup cycle picks a 0 to 3 cycle delay
               lcg_state = lcg_next(lcg_state);
               wait_cnt[i]   <= int'(lcg_state[17:16]);
               prdata_mac[i] <= mac_mem[i][paddr[7:2]];
               pready_mac[i] <= (lcg_state[17:16] == 2'd0) && !stall[i];
            end else if (psel_mac[i] && pready_mac[i]) begin
               // Transfer completes on this edge
               if (pwrite) begin
                  mac_mem[i][paddr[7:2]] <= pwdata;
               end
               pready_mac[i] <= 1'b0;
            end else if (psel_mac[i]) begin
               if (wait_cnt[i] > 0) begin
                  wait_cnt[i] <= wait_cnt[i] - 1;
               end
               pready_mac[i] <= (wait_cnt[i] <= 1) && !stall[i];
            end
         end
      end
   end

   //--------------------
   // Compare tasks
   //--------------------
   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_resp(input string name, input hresp_t got, input hresp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_sel(input string name, input slot_mask_t got, input slot_mask_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   // Expected STATUS word from hit, port, full and entry count
   function automatic word_t status_word(input logic hit, input logic [1:0] port,
                                         input logic full, input int count);
      word_t w;
      w       = '0;
      w[0]    = hit;
      w[2:1]  = port;
      w[3]    = full;
      w[11:8] = count[3:0];
      return w;
   endfunction

   function automatic word_t slot_addr(input int slot, input logic [15:0] offset);
      return SLOT_BASE + (word_t'(slot) << 16) + word_t'(offset);
   endfunction

   // Only MAC slots show up on psel_mac
   function automatic slot_mask_t expected_sel(input int slot);
      if ((slot >= 1) && (slot <= 4)) begin
         return slot_mask_t'(1) << slot;
      end
      return '0;
   endfunction

   function automatic string test_name(input int num);
      case (num)
         1:       return "reset values";
         2:       return "MAC slot write and read";
         3:       return "ALUT learn and lookup";
         4:       return "ALUT overflow";
         5:       return "unmapped address";
         6:       return "pready timeout";
         default: return "unknown";
      endcase
   endfunction

   //--------------------
   // Table building
   //--------------------
   task automatic table_row(input int test, input int slot, input logic [15:0] offset,
                            input logic write, input word_t wdata, input hresp_t resp,
                            input word_t rdata, input logic chk, input logic [3:0] stl);
      xfer_t x;
      x.test      = test;
      x.slot      = slot;
      x.offset    = offset;
      x.write     = write;
      x.wdata     = wdata;
      x.exp_resp  = resp;
      x.exp_rdata = rdata;
      x.chk_rdata = chk;
      x.stall     = stl;
      table_q.push_back(x);
   endtask

   task automatic write_row(input int test, input int slot, input logic [15:0] offset,
                            input word_t wdata);
      table_row(test, slot, offset, 1'b1, wdata, HRESP_OKAY, '0, 1'b0, 4'b0000);
   endtask

   task automatic read_row(input int test, input int slot, input logic [15:0] offset,
                           input word_t rdata);
      table_row(test, slot, offset, 1'b0, '0, HRESP_OKAY, rdata, 1'b1, 4'b0000);
   endtask

   task automatic learn_rows(input int test, input logic [47:0] mac, input logic [1:0] port);
      write_row(test, 0, ALUT_MAC_LO, mac[31:0]);
      write_row(test, 0, ALUT_MAC_HI, {16'h0000, mac[47:32]});
      write_row(test, 0, ALUT_PORT, {30'h0, port});
      write_row(test, 0, ALUT_CMD, 32'h1);
   endtask

   task automatic lookup_rows(input int test, input logic [47:0] mac, input word_t status);
      write_row(test, 0, ALUT_MAC_LO, mac[31:0]);
      write_row(test, 0, ALUT_MAC_HI, {16'h0000, mac[47:32]});
      write_row(test, 0, ALUT_CMD, 32'h2);
      read_row(test, 0, ALUT_STATUS, status);
   endtask

   task automatic build_table();
      // Test 2 writes one word per MAC slot
      for (int s = 1; s <= 4; s++) begin
         write_row(2, s, 16'(s * 4), 32'h1234_5600 + word_t'(s));
      end
      for (int s = 1; s <= 4; s++) begin
         read_row(2, s, 16'(s * 4), 32'h1234_5600 + word_t'(s));
      end
      // Test 3 learns three MACs then does lookups and a relearn
      learn_rows(3, 48'h0200_0000_00A1, 2'd1);
      learn_rows(3, 48'h0200_0000_00B2, 2'd2);
      learn_rows(3, 48'h0200_0000_00C3, 2'd3);
      lookup_rows(3, 48'h0200_0000_00B2, status_word(1'b1, 2'd2, 1'b0, 3));
      lookup_rows(3, 48'h0200_0000_00D4, status_word(1'b0, 2'd0, 1'b0, 3));
      learn_rows(3, 48'h0200_0000_00A1, 2'd3);
      lookup_rows(3, 48'h0200_0000_00A1, status_word(1'b1, 2'd3, 1'b0, 3));
      // Test 4 learns more new MACs than the table holds
      for (int k = 0; k <= ALUT_DEPTH; k++) begin
         learn_rows(4, 48'h0A00_0000_1000 + 48'(k), 2'((k + 1) % 4));
      end
      lookup_rows(4, 48'h0A00_0000_1000 + 48'(ALUT_DEPTH),
                  status_word(1'b0, 2'd0, 1'b1, ALUT_DEPTH));
      lookup_rows(4, 48'h0A00_0000_1000, status_word(1'b1, 2'd1, 1'b1, ALUT_DEPTH));
      // Test 5 goes above and below the slot map
      table_row(5, 5, 16'h0000, 1'b0, '0, HRESP_ERROR, '0, 1'b0, 4'b0000);
      table_row(5, -1, 16'h0010, 1'b1, 32'hFEED_0001, HRESP_ERROR, '0, 1'b0, 4'b0000);
      read_row(5, 1, 16'h0004, 32'h1234_5601);
      // Test 6 holds MAC2 never ready
      table_row(6, 3, 16'h0020, 1'b1, 32'hDEAD_0003, HRESP_ERROR, '0, 1'b0, 4'b0100);
      write_row(6, 4, 16'h0020, 32'hBEEF_0004);
      read_row(6, 4, 16'h0020, 32'hBEEF_0004);
      read_row(6, 1, 16'h0004, 32'h1234_5601);
      write_row(6, 3, 16'h0024, 32'hBEEF_0003);
      read_row(6, 3, 16'h0024, 32'hBEEF_0003);
   endtask

   //--------------------
   // AHB driver
   //--------------------
   task automatic ahb_transfer(input xfer_t x, output hresp_t resp, output hresp_t wait_resp,
                               output word_t rdata, output logic [3:0] sel_seen,
                               output word_t addr_seen, output word_t wdata_seen,
                               output logic write_seen, output int cycles,
                               output logic timed_out);
      sel_seen   = '0;
      addr_seen  = '0;
      wdata_seen = '0;
      write_seen = 1'b0;
      wait_resp  = HRESP_OKAY;
      cycles     = 0;
      // Address phase
      @(posedge hclk);
      stall  <= x.stall;
      hsel   <= 1'b1;
      haddr  <= slot_addr(x.slot, x.offset);
      htrans <= HTRANS_NONSEQ;
      hwrite <= x.write;
      // Accepted on this edge and the data phase follows
      @(posedge hclk);
      hsel   <= 1'b0;
      htrans <= HTRANS_IDLE;
      hwdata <= x.write ? x.wdata : '0;
      do begin
         @(negedge hclk);
         cycles++;
         if (psel_mac != 4'b0000) begin
            sel_seen   = sel_seen | psel_mac;
            addr_seen  = paddr;
            wdata_seen = pwdata;
            write_seen = pwrite;
         end
         // Response in the last stalled cycle
         if (!hready) begin
            wait_resp = hresp;
         end
      end while (!hready && (cycles < MAX_WAIT));
      timed_out = !hready;
      resp      = hresp;
      rdata     = hrdata;
   endtask

   task automatic finish_test(input int num);
      tests_run++;
      if (errors == test_err_mark) begin
         $display("Test %0d %s: ok", num, test_name(num));
      end else begin
         tests_failed++;
         $display("Test %0d %s: %0d errors", num, test_name(num), errors - test_err_mark);
      end
      test_err_mark = errors;
   endtask

   //--------------------
   // Main sequence
   //--------------------
   initial begin
      xfer_t      x;
      hresp_t     resp;
      hresp_t     wait_resp;
      word_t      rdata;
      word_t      addr_seen;
      word_t      wdata_seen;
      logic       write_seen;
      logic [3:0] sel_seen;
      int         cycles;
      logic       timed_out;
      logic       aborted;
      int         cur_test;

      rst_n         = 1'b0;
      hsel          = 1'b0;
      haddr         = '0;
      htrans        = HTRANS_IDLE;
      hwrite        = 1'b0;
      hwdata        = '0;
      hready_in     = 1'b1;
      errors        = 0;
      checks        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      test_err_mark = 0;
      aborted       = 1'b0;
      build_table();

      repeat (4) @(posedge hclk);
      rst_n <= 1'b1;
      @(negedge hclk);
      check_word("hready", word_t'(hready), 32'h1);
      check_resp("hresp", hresp, HRESP_OKAY);
      check_word("penable", word_t'(penable), 32'h0);
      check_sel("psel_mac", {psel_mac, 1'b0}, '0);
      finish_test(1);

      cur_test = table_q[0].test;
      for (int r = 0; (r < table_q.size()) && !aborted; r++) begin
         x = table_q[r];
         if (x.test != cur_test) begin
            finish_test(cur_test);
            cur_test = x.test;
         end
         ahb_transfer(x, resp, wait_resp, rdata, sel_seen, addr_seen, wdata_seen,
                      write_seen, cycles, timed_out);
         if (timed_out) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout: hready stayed low for %0d cycles in test %0d", cycles, x.test);
         end else begin
            check_resp("hresp", resp, x.exp_resp);
            // First ERROR cycle comes with hready still low
            check_resp("hresp with hready low", wait_resp, x.exp_resp);
            if (x.chk_rdata) begin
               check_word("hrdata", rdata, x.exp_rdata);
            end
            check_sel("psel_mac", {sel_seen, 1'b0}, expected_sel(x.slot));
            // Shared APB lines carry the AHB direction, address and data
            if ((expected_sel(x.slot) != '0) && (x.exp_resp == HRESP_OKAY)) begin
               check_word("pwrite", word_t'(write_seen), word_t'(x.write));
               check_word("paddr", addr_seen, slot_addr(x.slot, x.offset));
               if (x.write) begin
                  check_word("pwdata", wdata_seen, x.wdata);
               end
            end
            if (cycles > WAIT_LIMIT + 6) begin
               errors++;
               $display("Transfer in test %0d took %0d cycles, too long", x.test, cycles);
            end
         end
      end
      finish_test(cur_test);

      $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- verilog/ahb_apb_fsm.sv
//--------------------
// AHB-lite slave that runs each data phase as one APB transfer
// Holds a single transfer, stalls AHB with hready low until done
// Unmapped or timed-out transfers end with the two-cycle ERROR response
//--------------------
`timescale 1ns/1ps

module ahb_apb_fsm (
   input  logic                hclk,
   input  logic                rst_n,
   input  logic                hsel,
   input  apb_sub_pkg::word_t  haddr,
   input  apb_sub_pkg::htrans_t htrans,
   input  logic                hwrite,
   input  apb_sub_pkg::word_t  hwdata,
   input  logic                hready_in,
   input  logic                mapped,
   input  logic                expired,
   output apb_sub_pkg::word_t  hrdata,
   output logic                hready,
   output apb_sub_pkg::hresp_t hresp,
   output logic                run,
   apb_if.requester            bus
);
   import apb_sub_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      SETUP,
      ACCESS,
      ERR1,
      ERR2
   } state_t;

   state_t state;
   state_t state_nxt;
   logic   accept;
   word_t  paddr_q;
   logic   pwrite_q;
   word_t  pwdata_q;

   //--------------------
   // AHB side
   //--------------------
   // Only free in IDLE and the last ERROR cycle
   assign hready = (state == IDLE) || (state == ERR2);
   assign hresp  = ((state == ERR1) || (state == ERR2)) ? HRESP_ERROR : HRESP_OKAY;

   // Address phase seen by this slave
   assign accept = hsel && hready_in && hready &&
                   ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

   //--------------------
   // APB side
   //--------------------
   // Live haddr while free, so the decoder can judge it before SETUP
   assign bus.paddr   = hready ? haddr : paddr_q;
   assign bus.pwrite  = pwrite_q;
   // hwdata is valid during SETUP, held from the register afterwards
   assign bus.pwdata  = (state == SETUP) ? hwdata : pwdata_q;
   assign bus.psel    = (state == SETUP) || (state == ACCESS);
   assign bus.penable = (state == ACCESS);

   // Wait timer runs for every access cycle
   assign run = (state == ACCESS);

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE, ERR2: begin
            if (accept) begin
               state_nxt = mapped ? SETUP : ERR1;
            end else begin
               state_nxt = IDLE;
            end
         end
         SETUP:
            state_nxt = ACCESS;
         ACCESS: begin
            // A late pready still wins over the timeout
            if (bus.pready) begin
               state_nxt = IDLE;
            end else if (expired) begin
               state_nxt = ERR1;
            end
         end
         ERR1:
            state_nxt = ERR2;
         default:
            state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge hclk) begin
      if (!rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Transfer payload
   always_ff @(posedge hclk) begin
      if (accept) begin
         paddr_q  <= haddr;
         pwrite_q <= hwrite;
      end
      if (state == SETUP) begin
         pwdata_q <= hwdata;
      end
      // Read data shows on hrdata with hready high
      if ((state == ACCESS) && bus.pready) begin
         hrdata <= bus.prdata;
      end
   end

endmodule

//--- verilog/alut_regs.sv
//--------------------
// MAC address lookup table in APB slot 0
// Write MAC and PORT, then CMD bit 0 to learn or bit 1 to look up
// Results show in STATUS the cycle after the command
//--------------------
`timescale 1ns/1ps

module alut_regs #(
   parameter int ALUT_DEPTH = 8
) (
   input  logic     hclk,
   input  logic     rst_n,
   apb_if.completer regs
);
   import apb_sub_pkg::*;

   localparam int IDX_W = (ALUT_DEPTH > 1) ? $clog2(ALUT_DEPTH) : 1;
   localparam int CNT_W = $clog2(ALUT_DEPTH + 1);

   // Table entries below count are valid
   logic [47:0]      tbl_mac  [ALUT_DEPTH];
   logic [1:0]       tbl_port [ALUT_DEPTH];
   logic [CNT_W-1:0] count;
   // Programming registers
   word_t            mac_lo;
   logic [15:0]      mac_hi;
   logic [1:0]       port_q;
   // Status
   logic             hit_q;
   logic [1:0]       found_q;
   logic             full_q;
   // Command decode and search
   logic             wr_en;
   logic             learn;
   logic             lookup;
   logic             tbl_full;
   logic             match_any;
   logic [IDX_W-1:0] match_idx;

   // Single-cycle access, always ready
   assign regs.pready = 1'b1;

   assign wr_en    = regs.psel && regs.penable && regs.pwrite;
   assign learn    = wr_en && (regs.paddr[15:0] == ALUT_CMD) && regs.pwdata[0];
   assign lookup   = wr_en && (regs.paddr[15:0] == ALUT_CMD) && regs.pwdata[1];
   assign tbl_full = (count == CNT_W'(ALUT_DEPTH));

   // Search valid entries for the current MAC
   always_comb begin
      match_any = 1'b0;
      match_idx = '0;
      for (int i = 0; i < ALUT_DEPTH; i++) begin
         if ((CNT_W'(i) < count) && (tbl_mac[i] == {mac_hi, mac_lo})) begin
            match_any = 1'b1;
            match_idx = IDX_W'(i);
         end
      end
   end

   //--------------------
   // Table write
   //--------------------
   always_ff @(posedge hclk) begin
      if (learn && match_any) begin
         // Known MAC moved to another port
         tbl_port[match_idx] <= port_q;
      end else if (learn && !tbl_full) begin
         tbl_mac[IDX_W'(count)]  <= {mac_hi, mac_lo};
         tbl_port[IDX_W'(count)] <= port_q;
      end
   end

   //--------------------
   // Registers and status
   //--------------------
   always_ff @(posedge hclk) begin
      if (!rst_n) begin
         mac_lo  <= '0;
         mac_hi  <= '0;
         port_q  <= '0;
         count   <= '0;
         hit_q   <= 1'b0;
         found_q <= '0;
         full_q  <= 1'b0;
      end else begin
         if (wr_en && (regs.paddr[15:0] == ALUT_MAC_LO)) begin
            mac_lo <= regs.pwdata;
         end
         if (wr_en && (regs.paddr[15:0] == ALUT_MAC_HI)) begin
            mac_hi <= regs.pwdata[15:0];
         end
         if (wr_en && (regs.paddr[15:0] == ALUT_PORT)) begin
            port_q <= regs.pwdata[1:0];
         end
         // New MAC is appended or flags overflow
         if (learn && !match_any) begin
            if (tbl_full) begin
               full_q <= 1'b1;
            end else begin
               count <= count + 1'b1;
            end
         end
         if (lookup) begin
            hit_q   <= match_any;
            found_q <= match_any ? tbl_port[match_idx] : 2'b00;
         end
      end
   end

   // CMD and unused offsets read zero
   always_comb begin
      case (regs.paddr[15:0])
         ALUT_MAC_LO: regs.prdata = mac_lo;
         ALUT_MAC_HI: regs.prdata = {16'h0000, mac_hi};
         ALUT_PORT:   regs.prdata = {30'h0, port_q};
         ALUT_STATUS: regs.prdata = {20'h0, 4'(count), 4'h0, full_q, found_q, hit_q};
         default:     regs.prdata = '0;
      endcase
   end

endmodule

//--- verilog/apb_if.sv
//--------------------
// APB bus bundle between the bridge, the decoder and the ALUT
// Requester drives address, control and write data
//--------------------
`timescale 1ns/1ps

interface apb_if;
   import apb_sub_pkg::*;

   // Address phase and write payload
   word_t paddr;
   logic  pwrite;
   word_t pwdata;
   // Select strobe and access phase flag
   logic  psel;
   logic  penable;
   // Completer response
   word_t prdata;
   logic  pready;

   modport requester (
      output paddr, pwrite, pwdata, psel, penable,
      input  prdata, pready
   );

   modport completer (
      input  paddr, pwrite, pwdata, psel, penable,
      output prdata, pready
   );

endinterface

//--- verilog/apb_slot_decode.sv
//--------------------
// Splits the bridge's APB bus into the ALUT slot and four MAC slots
// Purely combinational with 64 KB per slot from SLOT_BASE
//--------------------
`timescale 1ns/1ps

module apb_slot_decode (
   apb_if.completer           bus,
   apb_if.requester           alut,
   output logic               mapped,
   output logic [3:0]         psel_mac,
   input  apb_sub_pkg::word_t prdata_mac0,
   input  apb_sub_pkg::word_t prdata_mac1,
   input  apb_sub_pkg::word_t prdata_mac2,
   input  apb_sub_pkg::word_t prdata_mac3,
   input  logic               pready_mac0,
   input  logic               pready_mac1,
   input  logic               pready_mac2,
   input  logic               pready_mac3
);
   import apb_sub_pkg::*;

   logic [15:0]          page;
   slot_mask_t           slot_hit;
   slot_mask_t           slot_sel;
   word_t                prdata_slot [NUM_SLOTS];
   logic [NUM_SLOTS-1:0] pready_slot;

   // Slot index from the upper half wraps for addresses below the base
   assign page = bus.paddr[31:16] - SLOT_BASE[31:16];

   always_comb begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
         slot_hit[i] = (page == 16'(i));
      end
   end

   assign mapped   = |slot_hit;
   assign slot_sel = slot_hit & {NUM_SLOTS{bus.psel}};

   //--------------------
   // Forward path
   //--------------------
   // ALUT sees only its offset
   assign alut.paddr   = {16'h0000, bus.paddr[15:0]};
   assign alut.pwrite  = bus.pwrite;
   assign alut.pwdata  = bus.pwdata;
   assign alut.psel    = slot_sel[0];
   assign alut.penable = bus.penable;
   assign psel_mac     = slot_sel[4:1];

   //--------------------
   // Return path
   //--------------------
   assign prdata_slot[0] = alut.prdata;
   assign prdata_slot[1] = prdata_mac0;
   assign prdata_slot[2] = prdata_mac1;
   assign prdata_slot[3] = prdata_mac2;
   assign prdata_slot[4] = prdata_mac3;
   assign pready_slot    = {pready_mac3, pready_mac2, pready_mac1, pready_mac0, alut.pready};

   // Nothing selected gives zero data and no ready
   always_comb begin
      bus.prdata = '0;
      bus.pready = 1'b0;
      for (int i = 0; i < NUM_SLOTS; i++) begin
         if (slot_sel[i]) begin
            bus.prdata = prdata_slot[i];
            bus.pready = pready_slot[i];
         end
      end
   end

endmodule

//--- verilog/apb_sub_pkg.sv
//--------------------
// Shared types and address map for the APB peripheral subsystem
// Imported by the bridge, the slot decoder and the ALUT registers
//--------------------

package apb_sub_pkg;

   // Data and address word
   typedef logic [31:0] word_t;

   // Only OKAY and ERROR AHB responses are produced
   typedef enum logic [1:0] {
      HRESP_OKAY  = 2'b00,
      HRESP_ERROR = 2'b01
   } hresp_t;

   // AHB transfer type
   typedef enum logic [1:0] {
      HTRANS_IDLE   = 2'b00,
      HTRANS_BUSY   = 2'b01,
      HTRANS_NONSEQ = 2'b10,
      HTRANS_SEQ    = 2'b11
   } htrans_t;

   //--------------------
   // Slot map
   //--------------------
   localparam int NUM_SLOTS = 5;
   // Bit 0 ALUT, bits 1 to 4 MAC0 to MAC3
   typedef logic [NUM_SLOTS-1:0] slot_mask_t;
   // Slot n starts at SLOT_BASE + n * 64 KB
   localparam word_t SLOT_BASE = 32'h00A0_0000;

   //--------------------
   // ALUT register offsets inside slot 0
   //--------------------
   localparam logic [15:0] ALUT_MAC_LO = 16'h0000;
   localparam logic [15:0] ALUT_MAC_HI = 16'h0004;
   localparam logic [15:0] ALUT_PORT   = 16'h0008;
   localparam logic [15:0] ALUT_CMD    = 16'h000C;
   localparam logic [15:0] ALUT_STATUS = 16'h0010;

endpackage

//--- verilog/apb_subsystem.sv
//--------------------
// APB peripheral subsystem behind an AHB-lite slave port
// Slot 0 is the internal ALUT, slots 1 to 4 go out as MAC ports
//--------------------
`timescale 1ns/1ps

module apb_subsystem #(
   parameter int WAIT_LIMIT = 16,
   parameter int ALUT_DEPTH = 8
) (
   // AHB-lite slave
   input  logic                 hclk,
   input  logic                 rst_n,
   input  logic                 hsel,
   input  apb_sub_pkg::word_t   haddr,
   input  apb_sub_pkg::htrans_t htrans,
   input  logic                 hwrite,
   input  apb_sub_pkg::word_t   hwdata,
   input  logic                 hready_in,
   output apb_sub_pkg::word_t   hrdata,
   output logic                 hready,
   output apb_sub_pkg::hresp_t  hresp,
   // Shared APB lines to the MACs
   output apb_sub_pkg::word_t   paddr,
   output logic                 pwrite,
   output logic                 penable,
   output apb_sub_pkg::word_t   pwdata,
   // MAC ports
   input  apb_sub_pkg::word_t   prdata_mac0,
   input  apb_sub_pkg::word_t   prdata_mac1,
   input  apb_sub_pkg::word_t   prdata_mac2,
   input  apb_sub_pkg::word_t   prdata_mac3,
   input  logic                 pready_mac0,
   input  logic                 pready_mac1,
   input  logic                 pready_mac2,
   input  logic                 pready_mac3,
   output logic                 psel_mac0,
   output logic                 psel_mac1,
   output logic                 psel_mac2,
   output logic                 psel_mac3
);

   logic       mapped;
   logic       expired;
   logic       run;
   logic [3:0] psel_mac;

   // Bridge to decoder, decoder to ALUT
   apb_if bus_if ();
   apb_if alut_if ();

   ahb_apb_fsm u_fsm (
      .hclk      (hclk),
      .rst_n     (rst_n),
      .hsel      (hsel),
      .haddr     (haddr),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hwdata    (hwdata),
      .hready_in (hready_in),
      .mapped    (mapped),
      .expired   (expired),
      .hrdata    (hrdata),
      .hready    (hready),
      .hresp     (hresp),
      .run       (run),
      .bus       (bus_if.requester)
   );

   apb_wait_timer #(
      .WAIT_LIMIT (WAIT_LIMIT)
   ) u_timer (
      .hclk    (hclk),
      .rst_n   (rst_n),
      .run     (run),
      .expired (expired)
   );

   apb_slot_decode u_decode (
      .bus         (bus_if.completer),
      .alut        (alut_if.requester),
      .mapped      (mapped),
      .psel_mac    (psel_mac),
      .prdata_mac0 (prdata_mac0),
      .prdata_mac1 (prdata_mac1),
      .prdata_mac2 (prdata_mac2),
      .prdata_mac3 (prdata_mac3),
      .pready_mac0 (pready_mac0),
      .pready_mac1 (pready_mac1),
      .pready_mac2 (pready_mac2),
      .pready_mac3 (pready_mac3)
   );

   alut_regs #(
      .ALUT_DEPTH (ALUT_DEPTH)
   ) u_alut (
      .hclk  (hclk),
      .rst_n (rst_n),
      .regs  (alut_if.completer)
   );

   // APB lines shared by all MAC ports
   assign paddr   = bus_if.paddr;
   assign pwrite  = bus_if.pwrite;
   assign penable = bus_if.penable;
   assign pwdata  = bus_if.pwdata;

   assign psel_mac0 = psel_mac[0];
   assign psel_mac1 = psel_mac[1];
   assign psel_mac2 = psel_mac[2];
   assign psel_mac3 = psel_mac[3];

endmodule

//--- verilog/apb_wait_timer.sv
//--------------------
// Access-phase watchdog for slow APB completers
// expired rises after run has been high WAIT_LIMIT cycles
//--------------------
`timescale 1ns/1ps

module apb_wait_timer #(
   parameter int WAIT_LIMIT = 16
) (
   input  logic hclk,
   input  logic rst_n,
   input  logic run,
   output logic expired
);

   localparam int                CNT_W   = $clog2(WAIT_LIMIT + 1);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(WAIT_LIMIT);

   logic [CNT_W-1:0] count;

   always_ff @(posedge hclk) begin
      if (!rst_n) begin
         count   <= '0;
         expired <= 1'b0;
      end else if (!run) begin
         // Idle between transfers
         count   <= '0;
         expired <= 1'b0;
      end else begin
         // Saturates at the limit
         if (count != CNT_MAX) begin
            count <= count + 1'b1;
         end
         // Flag when this cycle brings the count to the limit
         expired <= (count >= CNT_MAX - 1'b1);
      end
   end

endmodule
